// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f list.f --top-module tb_ip_ingress -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: axis_slice.sv
module axis_slice import tcp_ip_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       s_valid,
  output logic       s_ready,
  input  axis_beat_t s_beat,
  output logic       m_valid,
  input  logic       m_ready,
  output axis_beat_t m_beat
);

  logic       skid_valid;  // overflow entry holds a beat
  axis_beat_t skid_beat;
  logic       m_load;      // main entry free this cycle

  assign s_ready = !skid_valid;           // straight from a flop
  assign m_load  = m_ready || !m_valid;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (reset) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (m_load) begin
      m_valid    <= skid_valid || s_valid;  // skid drains first
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid <= 1'b1;                   // main stalled, park it
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (m_load) begin
      m_beat <= skid_valid ? skid_beat : s_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (!m_load && s_valid && s_ready) begin
      skid_beat <= s_beat;
    end
  end

endmodule

// File: frame_merger.sv
module frame_merger import tcp_ip_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       arp_valid,
  output logic       arp_ready,
  input  axis_beat_t arp_beat,
  input  logic       icmp_valid,
  output logic       icmp_ready,
  input  axis_beat_t icmp_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output out_beat_t  out_beat
);

  logic  locked;  // a frame owns the output
  lane_t grant;   // owner while locked
  lane_t prio;    // round robin favourite
  lane_t sel;     // lane on the output now
  logic  done;    // last beat leaves this cycle

  ////////////////////////////////////////
  // lane select
  ////////////////////////////////////////
  always_comb begin
    if (locked) begin
      sel = grant;
    end else if (arp_valid && icmp_valid) begin
      sel = prio;                                 // both waiting
    end else if (icmp_valid) begin
      sel = lane_icmp;
    end else begin
      sel = lane_arp;
    end
  end

  ////////////////////////////////////////
  // data path, no registers
  ////////////////////////////////////////
  always_comb begin
    out_valid     = (sel == lane_icmp) ? icmp_valid : arp_valid;
    out_beat.beat = (sel == lane_icmp) ? icmp_beat : arp_beat;
    out_beat.lane = sel;                          // tag with the source
    arp_ready     = out_ready && (sel == lane_arp);
    icmp_ready    = out_ready && (sel == lane_icmp);
    done          = out_valid && out_ready && out_beat.beat.last;
  end

  // lock as soon as a beat is shown so the payload holds until taken
  always_ff @(posedge aclk) begin
    if (reset) begin
      locked <= 1'b0;
      grant  <= lane_arp;
      prio   <= lane_arp;
    end else if (done) begin
      locked <= 1'b0;                             // frame boundary
      prio   <= (sel == lane_arp) ? lane_icmp : lane_arp;
    end else if (out_valid) begin
      locked <= 1'b1;
      grant  <= sel;
    end
  end

endmodule

// File: ip_classifier.sv
module ip_classifier import tcp_ip_pkg::*; (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  axis_beat_t            in_beat,
  output logic                  arp_valid,
  input  logic                  arp_ready,
  output axis_beat_t            arp_beat,
  output logic                  icmp_valid,
  input  logic                  icmp_ready,
  output axis_beat_t            icmp_beat,
  output logic [drop_cnt_w-1:0] drop_count
);

  typedef enum logic [1:0] {
    collect,  // holding the first header beats
    forward,  // replay then pass through
    discard   // swallow up to last
  } state_t;

  state_t     state;
  logic [1:0] cnt;                    // header beats held so far
  logic [1:0] rp;                     // replay pointer, 3 means pass through
  axis_beat_t hold [0:hdr_beats-1];   // stored header beats
  lane_t      sel_lane;               // lane of the frame in flight
  lane_t      hdr_lane;               // decision from the header
  hdr_word_u  hdr_word;               // third beat seen two ways
  logic [15:0] etype;
  axis_beat_t nxt;                    // next beat for the output reg
  axis_beat_t out_reg;
  lane_t      out_lane;
  logic       out_vld;
  logic       lane_ready;
  logic       ld;                     // output reg may load
  logic       src_vld;                // a beat is ready to load
  logic       in_fire;

  ////////////////////////////////////////
  // lane decision
  ////////////////////////////////////////
  always_comb begin
    hdr_word = in_beat.data;                                // third beat arrives now
    etype    = {hold[1].data[39:32], hold[1].data[47:40]};  // bytes 12 and 13
    hdr_lane = lane_drop;
    if (etype == ethertype_arp && net16(hdr_word.arp.ptype) == arp_ptype_ipv4) begin
      hdr_lane = lane_arp;
    end else if (etype == ethertype_ipv4 && hdr_word.ipv4.protocol == ip_proto_icmp) begin
      hdr_lane = lane_icmp;
    end
  end

  ////////////////////////////////////////
  // handshakes and replay mux
  ////////////////////////////////////////
  always_comb begin
    lane_ready = (out_lane == lane_arp) ? arp_ready : icmp_ready;
    ld         = !out_vld || lane_ready;          // empty or draining
    case (rp)
      2'd0:    nxt = hold[0];
      2'd1:    nxt = hold[1];
      2'd2:    nxt = hold[2];
      default: nxt = in_beat;                     // rest of the frame
    endcase
    src_vld = (state == forward) && ((rp != 2'(hdr_beats)) || in_valid);
    case (state)
      forward: in_ready = ld && (rp == 2'(hdr_beats));  // only once replay is done
      default: in_ready = 1'b1;                         // collect and discard absorb
    endcase
    in_fire = in_valid && in_ready;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state      <= collect;
      cnt        <= '0;
      rp         <= '0;
      sel_lane   <= lane_arp;
      drop_count <= '0;
    end else begin
      case (state)
        collect: if (in_fire) begin
          if (in_beat.last) begin
            cnt        <= '0;                     // too short to classify
            drop_count <= drop_count + 1'b1;
          end else if (cnt == 2'(hdr_beats - 1)) begin
            cnt      <= '0;
            rp       <= '0;
            sel_lane <= hdr_lane;
            state    <= (hdr_lane == lane_drop) ? discard : forward;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        forward: if (ld && src_vld) begin
          if (rp != 2'(hdr_beats)) begin
            rp <= rp + 1'b1;                      // next held beat
          end else if (in_beat.last) begin
            state <= collect;                     // frame handed over
          end
        end
        discard: if (in_fire && in_beat.last) begin
          drop_count <= drop_count + 1'b1;        // count on the last beat
          state      <= collect;
        end
        default: state <= collect;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == collect && in_fire) begin
      hold[cnt] <= in_beat;                       // header store
    end
  end

  ////////////////////////////////////////
  // output register, shared by both lanes
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (reset) begin
      out_vld <= 1'b0;
    end else if (ld) begin
      out_vld <= src_vld;
    end
  end

  always_ff @(posedge aclk) begin
    if (ld && src_vld) begin
      out_reg  <= nxt;
      out_lane <= sel_lane;                       // lane travels with the beat
    end
  end

  assign arp_valid  = out_vld && (out_lane == lane_arp);
  assign icmp_valid = out_vld && (out_lane == lane_icmp);
  assign arp_beat   = out_reg;
  assign icmp_beat  = out_reg;

endmodule

// File: ip_ingress_tests.txt
// frame header line holds beat count and lane (0 arp, 1 icmp, 2 dropped), 0 0 ends the list
// beat line holds data (byte 0 in the low bits), keep and last
4 0
0002ffffffffffff ff 0
0100060801000002 ff 0
0002010004060008 ff 0
0101a8c005000000 0f 1
5 1
00020a0000000002 ff 0
0045000801000002 ff 0
0140000034121c00 ff 0
0201a8c06a7b0000 ff 0
00000000beef0008 0f 1
4 2
00020a0000000002 ff 0
0045000801000002 ff 0
1140000034121c00 ff 0
0301a8c035003500 ff 1
4 0
0002ffffffffffff ff 0
0100060801000002 ff 0
0002010004060008 ff 0
0201a8c007000000 0f 1
2 2
0002ffffffffffff ff 0
0100060801000002 ff 1
4 1
00020a0000000002 ff 0
0045000801000002 ff 0
0140000034121c00 ff 0
0401a8c01c2d0000 3f 1
4 2
00020a0000000002 ff 0
0045000801000002 ff 0
0640000034121c00 ff 0
0501a8c050005000 ff 1
4 2
00020a0000000002 ff 0
0060dd8601000002 ff 0
0140000034121c00 ff 0
0601a8c000000000 ff 1
1 2
00000000000000aa 01 1
0 0

// File: ip_ingress_top.sv
module ip_ingress_top import tcp_ip_pkg::*; (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  axis_beat_t            in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output out_beat_t             out_beat,
  output logic [drop_cnt_w-1:0] drop_count
);

  ////////////////////////////////////////
  // classifier to slices
  ////////////////////////////////////////
  logic       arp_lane_valid, arp_lane_ready;
  axis_beat_t arp_lane;
  logic       icmp_lane_valid, icmp_lane_ready;
  axis_beat_t icmp_lane;

  // slices to merger
  logic       arp_m_valid, arp_m_ready;
  axis_beat_t arp_m_beat;
  logic       icmp_m_valid, icmp_m_ready;
  axis_beat_t icmp_m_beat;

  ip_classifier classifier (
    .aclk       (aclk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .arp_valid  (arp_lane_valid),
    .arp_ready  (arp_lane_ready),
    .arp_beat   (arp_lane),
    .icmp_valid (icmp_lane_valid),
    .icmp_ready (icmp_lane_ready),
    .icmp_beat  (icmp_lane),
    .drop_count (drop_count)
  );

  axis_slice arp_slice (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (arp_lane_valid),
    .s_ready (arp_lane_ready),
    .s_beat  (arp_lane),
    .m_valid (arp_m_valid),
    .m_ready (arp_m_ready),
    .m_beat  (arp_m_beat)
  );

  axis_slice icmp_slice (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (icmp_lane_valid),
    .s_ready (icmp_lane_ready),
    .s_beat  (icmp_lane),
    .m_valid (icmp_m_valid),
    .m_ready (icmp_m_ready),
    .m_beat  (icmp_m_beat)
  );

  frame_merger merger (
    .aclk       (aclk),
    .reset      (reset),
    .arp_valid  (arp_m_valid),
    .arp_ready  (arp_m_ready),
    .arp_beat   (arp_m_beat),
    .icmp_valid (icmp_m_valid),
    .icmp_ready (icmp_m_ready),
    .icmp_beat  (icmp_m_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

// File: list.f
tcp_ip_pkg.sv
ip_classifier.sv
axis_slice.sv
frame_merger.sv
ip_ingress_top.sv
tb_ip_ingress.sv

// File: tb_ip_ingress.sv
module tb_ip_ingress import tcp_ip_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_depth = 256;

  logic                  aclk = 1'b0;
  logic                  reset;
  logic                  in_valid;
  logic                  in_ready;
  axis_beat_t            in_beat;
  logic                  out_valid;
  logic                  out_ready = 1'b0;  // held low until the first edge
  out_beat_t             out_beat;
  logic [drop_cnt_w-1:0] drop_count;

  logic [63:0] mem [0:mem_depth-1];  // raw words of the tests file
  axis_beat_t  drv_q [$];            // all input beats in order
  axis_beat_t  arp_q [$];            // expected beats, arp lane
  axis_beat_t  icmp_q [$];           // expected beats, icmp lane
  int          arp_id [$];           // frame numbers per lane
  int          icmp_id [$];
  int          exp_drops;
  int          kept_frames;
  int          total_beats;
  int          limit = 1000;         // recomputed from the file
  int          cycles;
  int          frames_seen;
  int          pass_cnt;
  int          fail_cnt;
  integer      seed = 72;
  logic        in_frame = 1'b0;      // output frame open
  lane_t       frame_lane;
  int          frame_id;
  int          frame_beats;
  int          frame_errs;

  always #5 aclk = ~aclk;  // 10 ns period

  ip_ingress_top dut0 (
    .aclk       (aclk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat),
    .drop_count (drop_count)
  );

  ////////////////////////////////////////
  // timeout and back-pressure
  ////////////////////////////////////////
  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run timed out after %0d cycles with %0d of %0d frames out",
               cycles, frames_seen, kept_frames);
      $display("=== FAIL ===");
      $finish;
    end
  end

  always @(posedge aclk) begin
    #1;
    if (reset) begin
      out_ready = 1'b0;
    end else begin
      out_ready = ($random(seed) % 4) != 0;  // low about one cycle in four
    end
  end

  // file words into beats, lane queues and frame counts
  task automatic load_tests();
    int         p;
    int         nb;
    int         ln;
    int         fr;
    axis_beat_t b;
    p  = 0;
    fr = 0;
    while (p < mem_depth - 2 && mem[p] != '0) begin  // 0 0 header ends the list
      nb = int'(mem[p]);
      ln = int'(mem[p+1]);
      p  = p + 2;
      fr++;
      for (int k = 0; k < nb; k++) begin
        b.data = mem[p];
        b.keep = mem[p+1][keep_w-1:0];
        b.last = mem[p+2][0];
        p      = p + 3;
        drv_q.push_back(b);
        if (ln == 0) begin
          arp_q.push_back(b);
        end else if (ln == 1) begin
          icmp_q.push_back(b);
        end
      end
      total_beats += nb;
      if (ln == 0) begin
        arp_id.push_back(fr);
        kept_frames++;
      end else if (ln == 1) begin
        icmp_id.push_back(fr);
        kept_frames++;
      end else begin
        exp_drops++;
      end
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_beat(input axis_beat_t b);
    logic taken;
    in_valid = 1'b1;
    in_beat  = b;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = in_ready;  // settled by mid cycle
      @(posedge aclk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////
  task automatic take_beat();
    axis_beat_t exp_b;
    logic       have;
    have  = 1'b0;
    exp_b = '0;
    if (!in_frame) begin  // first beat opens a frame
      in_frame    = 1'b1;
      frame_lane  = out_beat.lane;
      frame_beats = 0;
      frame_errs  = 0;
      frame_id    = 0;
      if (frame_lane == lane_arp && arp_id.size() > 0) begin
        frame_id = arp_id.pop_front();
      end else if (frame_lane == lane_icmp && icmp_id.size() > 0) begin
        frame_id = icmp_id.pop_front();
      end
    end else if (out_beat.lane != frame_lane) begin
      fail_cnt++;
      frame_errs++;
      $display("Fail %0t: lane tag %0d inside a frame of lane %0d",
               $time, out_beat.lane, frame_lane);
    end else begin
      pass_cnt++;
    end
    frame_beats++;
    if (out_beat.lane == lane_arp && arp_q.size() > 0) begin
      exp_b = arp_q.pop_front();
      have  = 1'b1;
    end else if (out_beat.lane == lane_icmp && icmp_q.size() > 0) begin
      exp_b = icmp_q.pop_front();
      have  = 1'b1;
    end
    if (!have) begin
      fail_cnt++;
      frame_errs++;
      $display("an output beat with lane tag %0d came out when none was expected",
               out_beat.lane);
    end else if (out_beat.beat !== exp_b) begin
      fail_cnt++;
      frame_errs++;
      $display("Fail %0t: lane %0d got %h %h %b expected %h %h %b", $time, out_beat.lane,
               out_beat.beat.data, out_beat.beat.keep, out_beat.beat.last,
               exp_b.data, exp_b.keep, exp_b.last);
    end else begin
      pass_cnt++;
    end
    if (out_beat.beat.last) begin
      in_frame = 1'b0;
      frames_seen++;
      $display("frame %0d done on lane %0d with %0d beats and %0d errors",
               frame_id, frame_lane, frame_beats, frame_errs);
    end
  endtask

  always @(negedge aclk) begin
    if (!reset && out_valid && out_ready) begin
      take_beat();  // beat moves on the next edge
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    $readmemh("ip_ingress_tests.txt", mem);
    load_tests();
    limit = 8 * total_beats + 200;
    repeat (3) @(posedge aclk);
    #1;
    reset = 1'b0;
    @(negedge aclk);  // idle outputs before any input
    if (out_valid !== 1'b0 || drop_count !== '0 || in_ready !== 1'b1) begin
      fail_cnt++;
      $display("Fail %0t: after reset valid %b drops %0d ready %b",
               $time, out_valid, drop_count, in_ready);
    end else begin
      pass_cnt++;
    end
    $display("reset check done");
    @(posedge aclk);
    #1;
    for (int i = 0; i < drv_q.size(); i++) begin
      send_beat(drv_q[i]);
      if (drv_q[i].last) begin
        repeat (i % 3) begin  // idle gap between frames
          @(posedge aclk);
          #1;
        end
      end
    end
    while (frames_seen < kept_frames) begin
      @(posedge aclk);
    end
    repeat (20) @(posedge aclk);  // nothing more may come out
    if (drop_count !== drop_cnt_w'(exp_drops)) begin
      fail_cnt++;
      $display("Fail %0t: drop count %0d expected %0d", $time, drop_count, exp_drops);
    end else begin
      pass_cnt++;
    end
    $display("drop count check done with %0d drops", drop_count);
    $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tcp_ip_pkg.sv
package tcp_ip_pkg;

  ////////////////////////////////////////
  // stream widths
  ////////////////////////////////////////
  localparam int data_w     = 64;  // stream data word
  localparam int keep_w     = 8;   // one enable per byte
  localparam int hdr_beats  = 3;   // beats held before the lane decision
  localparam int drop_cnt_w = 16;  // dropped frame counter

  // header constants, all in network order
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [15:0] ethertype_arp  = 16'h0806;
  localparam logic [7:0]  ip_proto_icmp  = 8'd1;
  localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;

  typedef struct packed {
    logic [data_w-1:0] data;  // byte lane 0 holds the earliest byte
    logic [keep_w-1:0] keep;
    logic              last;  // closes the frame
  } axis_beat_t;

  typedef enum logic [1:0] {
    lane_arp  = 2'd0,
    lane_icmp = 2'd1,
    lane_drop = 2'd2  // classifier only
  } lane_t;

  typedef struct packed {
    axis_beat_t beat;
    lane_t      lane;  // source lane of the frame
  } out_beat_t;

  ////////////////////////////////////////
  // third beat, frame bytes 16 to 23
  ////////////////////////////////////////
  // fields are listed from byte 23 down to byte 16, and in a multi-byte
  // field element [0] is the earlier, more significant byte
  typedef struct packed {
    logic [7:0]      protocol;    // byte 23
    logic [7:0]      ttl;         // byte 22
    logic [1:0][7:0] flags_frag;  // bytes 20..21
    logic [1:0][7:0] ident;       // bytes 18..19
    logic [1:0][7:0] total_len;   // bytes 16..17
  } ipv4_view_t;

  typedef struct packed {
    logic [1:0][7:0] sha_hi;  // first two bytes of sender mac
    logic [1:0][7:0] opcode;  // bytes 20..21
    logic [7:0]      plen;    // byte 19
    logic [7:0]      hlen;    // byte 18
    logic [1:0][7:0] ptype;   // bytes 16..17
  } arp_view_t;

  typedef union packed {
    ipv4_view_t ipv4;
    arp_view_t  arp;
  } hdr_word_u;

  // two stream bytes back to a 16 bit network order value
  function automatic logic [15:0] net16(input logic [1:0][7:0] b);
    return {b[0], b[1]};
  endfunction

endpackage
